/* Makefile */
VERILATOR ?= verilator
TOP       ?= calc_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -x "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* dv/calc_assertions.sv */
// concurrent checks on scan order, page stepping, exe_done release and conversion latency
`timescale 1ns/1ns
`default_nettype none

module calc_assertions (
    input logic                              clk,
    input logic                              rst_n,
    input logic [calc_pkg::BUTTON_WIDTH-1:0] button_pulse,
    input logic                              in_input_a,
    input logic                              capture_b,
    input logic                              cal_board_exe_done,
    input logic [3:0]                        cal_board_digit_ctrl,
    input logic [2:0]                        cal_board_display_stage
);

    int assert_errors = 0;

    // digit select moves one position up, 3 wraps to 0
    scan_order: assert property (@(posedge clk) disable iff (!rst_n)
        (cal_board_digit_ctrl != 4'hF && $past(cal_board_digit_ctrl) != 4'hF &&
         cal_board_digit_ctrl != $past(cal_board_digit_ctrl))
        |-> cal_board_digit_ctrl == {$past(cal_board_digit_ctrl[2:0]),
                                     $past(cal_board_digit_ctrl[3])})
        else begin
            assert_errors++;
            $error("digit select did not rotate to the next position");
        end

    // page 2 is reached only by mid while a result is shown
    stage_step: assert property (@(posedge clk) disable iff (!rst_n)
        (cal_board_display_stage == 3'd2 && $past(cal_board_display_stage) != 3'd2)
        |-> $past(button_pulse[calc_pkg::BTN_MID] && cal_board_exe_done))
        else begin
            assert_errors++;
            $error("display_stage stepped to 2 without a mid press on a result");
        end

    done_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cal_board_exe_done) |-> in_input_a && $past(button_pulse[calc_pkg::BTN_MID]))
        else begin
            assert_errors++;
            $error("exe_done fell without a mid press or not into input A");
        end

    // exe, start, 20 shifts, done, then display
    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        capture_b |-> ##(calc_pkg::MAG_WIDTH + 3) $rose(cal_board_exe_done))
        else begin
            assert_errors++;
            $error("exe_done did not rise at the fixed latency after capture");
        end

endmodule

bind calc_top calc_assertions u_assertions (.*);

`default_nettype wire

/* dv/calc_tb.sv */
// calculator testbench with clock, reset, button presses, display checks and timeout
`timescale 1ns/1ns
`default_nettype none

module calc_tb;

    // roughly 75 presses of 16 cycles plus conversions and scans, doubled
    localparam int TIMEOUT_CYCLES = 4000;

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic [calc_pkg::BUTTON_WIDTH-1:0] board_cal_button;
    logic [calc_pkg::OP_WIDTH-1:0]     board_cal_switchs;
    logic [3:0]                        cal_board_digit_ctrl;
    logic [7:0]                        cal_board_digit_seg;
    logic                              cal_board_exe_done;
    logic [2:0]                        cal_board_display_stage;
    int                                value_errors = 0;
    int                                cycles = 0;

    calc_top #(.debounce_bits(2), .scan_bits(2)) UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp) else begin
            value_errors++;
            $display("FAILED %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // held 8 cycles, released 8, enough for a 2 bit debounce
    task automatic press(input int btn);
        board_cal_button[btn] = 1'b1;
        repeat (8) @(negedge clk);
        board_cal_button[btn] = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic check_position(input int pos, input logic [3:0] code, input string what);
        logic [3:0] sel;
        sel = ~(4'b0001 << pos);
        @(negedge clk);
        while (cal_board_digit_ctrl !== sel) @(negedge clk);
        check_value(cal_board_digit_seg, calc_pkg::SEG_TABLE[code],
                    $sformatf("%s, segments at position %0d", what, pos));
    endtask

    function automatic logic [3:0] result_code(input int value, input int page_no, input int pos);
        int mag;
        int idx;
        mag = (value < 0) ? -value : value;
        idx = pos;
        if (pos == calc_pkg::ENTRY_DIGITS) begin
            return (value < 0) ? calc_pkg::CODE_MINUS : calc_pkg::CODE_BLANK;
        end
        // above 999 the upper three digits come first
        if (mag > 999 && page_no == 0) begin
            idx = pos + calc_pkg::ENTRY_DIGITS;
        end
        repeat (idx) mag = mag / 10;
        return 4'(mag % 10);
    endfunction

    task automatic check_result(input int value, input int page_no, input string what);
        for (int pos = 0; pos < 4; pos++) begin
            check_position(pos, result_code(value, page_no, pos), what);
        end
    endtask

    // units first, then tens and hundreds, cursor ends on the sign
    task automatic enter_operand(input int value);
        int mag;
        int d;
        mag = (value < 0) ? -value : value;
        for (int i = 0; i < calc_pkg::ENTRY_DIGITS; i++) begin
            d = mag % 10;
            mag = mag / 10;
            if (d > 5) begin
                repeat (10 - d) press(calc_pkg::BTN_DOWN);
            end else begin
                repeat (d) press(calc_pkg::BTN_UP);
            end
            press(calc_pkg::BTN_LEFT);
        end
        if (value < 0) press(calc_pkg::BTN_UP);
        press(calc_pkg::BTN_MID);
    endtask

    task automatic wait_done();
        while (!cal_board_exe_done) @(negedge clk);
    endtask

    task automatic check_blank(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value(cal_board_digit_ctrl, 4'hF, "digit_ctrl with no operation");
        end
    endtask

    initial begin
        rst_n = 1'b0;
        board_cal_button = '0;
        board_cal_switchs = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value(cal_board_exe_done, 0, "exe_done after reset");
        check_value(cal_board_display_stage, 1, "display_stage after reset");

        // editing operand a by hand
        press(calc_pkg::BTN_DOWN);
        check_position(0, 4'd9, "down on a cleared digit");
        press(calc_pkg::BTN_LEFT);
        press(calc_pkg::BTN_UP);
        check_position(1, 4'd1, "up on digit1");
        press(calc_pkg::BTN_LEFT);
        press(calc_pkg::BTN_LEFT);
        press(calc_pkg::BTN_UP);
        check_position(3, calc_pkg::CODE_MINUS, "sign toggle");
        board_cal_switchs = 3'b001;
        press(calc_pkg::BTN_MID);
        enter_operand(0);
        wait_done();
        check_result(-19 + 0, 0, "edited operand plus zero");
        press(calc_pkg::BTN_MID);

        // add wins over subtract
        board_cal_switchs = 3'b011;
        enter_operand(-5);
        enter_operand(12);
        wait_done();
        check_result(-5 + 12, 0, "add");
        check_value(cal_board_exe_done, 1, "exe_done while showing add");
        check_value(cal_board_display_stage, 1, "display_stage for add");
        press(calc_pkg::BTN_MID);
        check_value(cal_board_exe_done, 0, "exe_done after add");

        board_cal_switchs = 3'b110;
        enter_operand(25);
        enter_operand(300);
        wait_done();
        check_result(25 - 300, 0, "subtract");
        press(calc_pkg::BTN_MID);

        board_cal_switchs = 3'b100;
        enter_operand(999);
        enter_operand(999);
        wait_done();
        check_value(cal_board_display_stage, 1, "display_stage on page 1");
        check_result(999 * 999, 0, "multiply page 1");
        press(calc_pkg::BTN_MID);
        check_value(cal_board_display_stage, 2, "display_stage on page 2");
        check_result(999 * 999, 1, "multiply page 2");
        press(calc_pkg::BTN_MID);
        check_value(cal_board_exe_done, 0, "exe_done after multiply");
        check_position(0, 4'd0, "cleared entry after multiply");

        // no switch set
        board_cal_switchs = 3'b000;
        enter_operand(0);
        enter_operand(0);
        wait_done();
        check_blank(20);
        press(calc_pkg::BTN_MID);
        check_value(cal_board_exe_done, 0, "exe_done after no operation");

        $display("value errors: %0d, assertion errors: %0d",
                 value_errors, UUT.u_assertions.assert_errors);
        if (value_errors == 0 && UUT.u_assertions.assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/bin_to_bcd.sv */
// sequential shift-and-add-three binary to decimal converter
`timescale 1ns/1ns
`default_nettype none

module bin_to_bcd (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    start,
    input  logic [calc_pkg::MAG_WIDTH-1:0]                          magnitude,
    output logic [calc_pkg::RESULT_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] bcd,
    output logic                                                    done
);

    localparam int BCD_W = calc_pkg::RESULT_DIGITS * calc_pkg::DIGIT_WIDTH;
    localparam int IDX_W = $clog2(calc_pkg::MAG_WIDTH);

    logic [BCD_W-1:0] src, adjusted;
    logic [IDX_W-1:0] bit_idx, idx;
    logic             busy, bit_in;

    // the start cycle already shifts in the top bit
    always_comb begin
        src = start ? '0 : bcd;
        idx = start ? '0 : bit_idx;
        for (int k = 0; k < calc_pkg::RESULT_DIGITS; k++) begin
            adjusted[k*4 +: 4] = (src[k*4 +: 4] >= 4'd5) ? src[k*4 +: 4] + 4'd3 : src[k*4 +: 4];
        end
        bit_in = magnitude[IDX_W'(calc_pkg::MAG_WIDTH - 1) - idx];
    end

    always_ff @(posedge clk) begin
        if (start || busy) bcd <= {adjusted[BCD_W-2:0], bit_in};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_idx <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                bit_idx <= IDX_W'(1);
            end else if (busy) begin
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == IDX_W'(calc_pkg::MAG_WIDTH - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/button_conditioner.sv */
// button synchronizer, debouncer, priority qualifier and press-edge detector
`timescale 1ns/1ns
`default_nettype none

module button_conditioner #(
    parameter int debounce_bits = calc_pkg::DEBOUNCE_BITS_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [calc_pkg::BUTTON_WIDTH-1:0] board_cal_button,
    output logic [calc_pkg::BUTTON_WIDTH-1:0] button_pulse
);

    logic [calc_pkg::BUTTON_WIDTH-1:0] sync1, sync2, last, stable, qual, qual_q;
    logic [debounce_bits-1:0]          stable_cnt;
    logic                              lower;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync1      <= '0;
            sync2      <= '0;
            last       <= '0;
            stable     <= '0;
            stable_cnt <= '0;
            qual_q     <= '0;
        end else begin
            sync1  <= board_cal_button;
            sync2  <= sync1;
            last   <= sync2;
            qual_q <= qual;
            // any change restarts the count
            if (sync2 != last) begin
                stable_cnt <= '0;
            end else if (&stable_cnt) begin
                stable <= last;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        lower = 1'b0;
        for (int i = 0; i < calc_pkg::BUTTON_WIDTH; i++) begin
            qual[i] = stable[i] & (~lower | (i == calc_pkg::BTN_LEFT));
            lower   = lower | stable[i];
        end
    end

    assign button_pulse = qual & ~qual_q;

endmodule

`default_nettype wire

/* verilog/calc_control.sv */
// main phase machine, operand strobes, conversion start and display page counter
`timescale 1ns/1ns
`default_nettype none

module calc_control (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mid,
    input  logic       bcd_done,
    input  logic       bcd_upper_nonzero,
    input  logic       invalid,
    output logic       in_input_a,
    output logic       in_input_b,
    output logic       in_exe,
    output logic       in_display,
    output logic       clear_entry,
    output logic       capture_a,
    output logic       capture_b,
    output logic       bcd_start,
    output logic       window_high,
    output logic       exe_done,
    output logic [2:0] display_stage
);

    logic [5:0] phase, phase_next;
    logic       page;
    logic       last_page;

    assign in_input_a = (phase == calc_pkg::PH_INPUT_A);
    assign in_input_b = (phase == calc_pkg::PH_INPUT_B);
    assign in_exe     = (phase == calc_pkg::PH_EXE);
    assign in_display = (phase == calc_pkg::PH_DISPLAY);

    // an invalid result has a single page
    assign last_page = invalid | ~bcd_upper_nonzero | page;

    always_comb begin
        phase_next = phase;
        unique case (phase)
            calc_pkg::PH_IDLE:    phase_next = calc_pkg::PH_INPUT_A;
            calc_pkg::PH_INPUT_A: if (mid) phase_next = calc_pkg::PH_INPUT_B;
            calc_pkg::PH_INPUT_B: if (mid) phase_next = calc_pkg::PH_EXE;
            calc_pkg::PH_EXE:     phase_next = calc_pkg::PH_CONVERT;
            calc_pkg::PH_CONVERT: if (bcd_done) phase_next = calc_pkg::PH_DISPLAY;
            calc_pkg::PH_DISPLAY: if (mid && last_page) phase_next = calc_pkg::PH_INPUT_A;
            default:              phase_next = calc_pkg::PH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase     <= calc_pkg::PH_IDLE;
            page      <= 1'b0;
            bcd_start <= 1'b0;
        end else begin
            phase <= phase_next;
            // exe lasts one cycle, so start lands on the first convert cycle
            bcd_start <= in_exe;
            if (phase == calc_pkg::PH_CONVERT) begin
                page <= 1'b0;
            end else if (in_display && mid && !last_page) begin
                page <= 1'b1;
            end
        end
    end

    assign clear_entry = (phase_next != phase) &&
                         (phase_next == calc_pkg::PH_INPUT_A ||
                          phase_next == calc_pkg::PH_INPUT_B);
    assign capture_a     = in_input_a & mid;
    assign capture_b     = in_input_b & mid;
    assign window_high   = bcd_upper_nonzero & ~page;
    assign exe_done      = in_display;
    assign display_stage = {2'b00, page} + 3'd1;

endmodule

`default_nettype wire

/* verilog/calc_pkg.sv */
// calculator widths, button and switch indices, phase and cursor codes, segment table
`default_nettype none

package calc_pkg;

    localparam int DIGIT_WIDTH   = 4;
    localparam int ENTRY_DIGITS  = 3;
    localparam int OPERAND_WIDTH = 10;
    localparam int MAG_WIDTH     = 20;
    localparam int RESULT_DIGITS = 6;

    // buttons, lower index wins except left
    localparam int BUTTON_WIDTH = 5;
    localparam int BTN_MID   = 0;
    localparam int BTN_UP    = 1;
    localparam int BTN_DOWN  = 2;
    localparam int BTN_RIGHT = 3;
    localparam int BTN_LEFT  = 4;

    localparam int OP_WIDTH = 3;
    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_MUL = 2;

    localparam logic [DIGIT_WIDTH-1:0] CODE_BLANK = 4'd10;
    localparam logic [DIGIT_WIDTH-1:0] CODE_MINUS = 4'd11;

    // active low, bit 0 is the decimal point
    localparam logic [7:0] SEG_TABLE [0:11] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1111,
        8'b0000_0001, 8'b0001_1001, 8'b1111_1111, 8'b1111_1101
    };

    localparam logic [5:0] PH_IDLE    = 6'b000001;
    localparam logic [5:0] PH_INPUT_A = 6'b000010;
    localparam logic [5:0] PH_INPUT_B = 6'b000100;
    localparam logic [5:0] PH_EXE     = 6'b001000;
    localparam logic [5:0] PH_CONVERT = 6'b010000;
    localparam logic [5:0] PH_DISPLAY = 6'b100000;

    // left shifts the cursor one bit up
    localparam logic [3:0] CUR_DIGIT0 = 4'b0001;
    localparam logic [3:0] CUR_DIGIT1 = 4'b0010;
    localparam logic [3:0] CUR_DIGIT2 = 4'b0100;
    localparam logic [3:0] CUR_SIGN   = 4'b1000;

    localparam int DEBOUNCE_BITS_DEFAULT = 16;
    localparam int SCAN_BITS_DEFAULT     = 10;

endpackage

`default_nettype wire

/* verilog/calc_top.sv */
// calculator top level connecting buttons, entry, control, alu, converter and display
`timescale 1ns/1ns
`default_nettype none

module calc_top #(
    parameter int debounce_bits = calc_pkg::DEBOUNCE_BITS_DEFAULT,
    parameter int scan_bits     = calc_pkg::SCAN_BITS_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [calc_pkg::BUTTON_WIDTH-1:0] board_cal_button,
    input  logic [calc_pkg::OP_WIDTH-1:0]     board_cal_switchs,
    output logic [3:0]                        cal_board_digit_ctrl,
    output logic [7:0]                        cal_board_digit_seg,
    output logic                              cal_board_exe_done,
    output logic [2:0]                        cal_board_display_stage
);

    localparam int BCD_W = calc_pkg::RESULT_DIGITS * calc_pkg::DIGIT_WIDTH;

    logic [calc_pkg::BUTTON_WIDTH-1:0] button_pulse;
    logic [calc_pkg::DIGIT_WIDTH-1:0]  digit0, digit1, digit2;
    logic [calc_pkg::MAG_WIDTH-1:0]    magnitude;
    logic [BCD_W-1:0]                  bcd;
    logic in_input_a, in_input_b, in_input, in_exe, in_display;
    logic clear_entry, capture_a, capture_b, bcd_start, bcd_done;
    logic negative, result_negative, invalid, window_high, bcd_upper_nonzero;

    assign in_input = in_input_a | in_input_b;
    // a second page is needed when the upper three digits are not all zero
    assign bcd_upper_nonzero = |bcd[BCD_W-1:calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH];

    button_conditioner #(.debounce_bits(debounce_bits)) u_buttons (
        .clk(clk), .rst_n(rst_n),
        .board_cal_button(board_cal_button),
        .button_pulse(button_pulse)
    );

    operand_entry u_entry (
        .clk(clk), .rst_n(rst_n),
        .active(in_input), .clear_entry(clear_entry),
        .left(button_pulse[calc_pkg::BTN_LEFT]), .right(button_pulse[calc_pkg::BTN_RIGHT]),
        .up(button_pulse[calc_pkg::BTN_UP]), .down(button_pulse[calc_pkg::BTN_DOWN]),
        .digit0(digit0), .digit1(digit1), .digit2(digit2), .negative(negative)
    );

    calc_control u_control (
        .clk(clk), .rst_n(rst_n),
        .mid(button_pulse[calc_pkg::BTN_MID]), .bcd_done(bcd_done),
        .bcd_upper_nonzero(bcd_upper_nonzero), .invalid(invalid),
        .in_input_a(in_input_a), .in_input_b(in_input_b),
        .in_exe(in_exe), .in_display(in_display),
        .clear_entry(clear_entry), .capture_a(capture_a), .capture_b(capture_b),
        .bcd_start(bcd_start), .window_high(window_high),
        .exe_done(cal_board_exe_done), .display_stage(cal_board_display_stage)
    );

    operand_alu u_alu (
        .clk(clk), .rst_n(rst_n),
        .capture_a(capture_a), .capture_b(capture_b), .execute(in_exe),
        .digit0(digit0), .digit1(digit1), .digit2(digit2), .negative(negative),
        .switches(board_cal_switchs),
        .result_negative(result_negative), .magnitude(magnitude), .invalid(invalid)
    );

    bin_to_bcd u_bcd (
        .clk(clk), .rst_n(rst_n),
        .start(bcd_start), .magnitude(magnitude),
        .bcd(bcd), .done(bcd_done)
    );

    display_scan #(.scan_bits(scan_bits)) u_display (
        .clk(clk), .rst_n(rst_n),
        .in_input(in_input), .in_display(in_display), .invalid(invalid),
        .digit0(digit0), .digit1(digit1), .digit2(digit2), .entry_negative(negative),
        .bcd(bcd), .result_negative(result_negative), .window_high(window_high),
        .digit_ctrl(cal_board_digit_ctrl), .digit_seg(cal_board_digit_seg)
    );

endmodule

`default_nettype wire

/* verilog/display_scan.sv */
// scan tick, digit rotation, digit code selection and segment encoding
`timescale 1ns/1ns
`default_nettype none

module display_scan #(
    parameter int scan_bits = calc_pkg::SCAN_BITS_DEFAULT
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    in_input,
    input  logic                                                    in_display,
    input  logic                                                    invalid,
    input  logic [calc_pkg::DIGIT_WIDTH-1:0]                        digit0,
    input  logic [calc_pkg::DIGIT_WIDTH-1:0]                        digit1,
    input  logic [calc_pkg::DIGIT_WIDTH-1:0]                        digit2,
    input  logic                                                    entry_negative,
    input  logic [calc_pkg::RESULT_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] bcd,
    input  logic                                                    result_negative,
    input  logic                                                    window_high,
    output logic [3:0]                                              digit_ctrl,
    output logic [7:0]                                              digit_seg
);

    logic [scan_bits-1:0]              tick_cnt;
    logic [1:0]                        pos;
    logic [2:0]                        bcd_idx;
    logic                              enable, sign_neg;
    logic [calc_pkg::DIGIT_WIDTH-1:0]  code;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            pos      <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            if (&tick_cnt) pos <= pos + 2'd1;
        end
    end

    always_comb begin
        enable   = in_input | (in_display & ~invalid);
        sign_neg = in_input ? entry_negative : result_negative;
        bcd_idx  = {1'b0, pos} + (window_high ? 3'(calc_pkg::ENTRY_DIGITS) : 3'd0);
        code     = calc_pkg::CODE_BLANK;
        if (!enable) begin
            code = calc_pkg::CODE_BLANK;
        end else if (pos == 2'(calc_pkg::ENTRY_DIGITS)) begin
            // sign sits in the leftmost position
            code = sign_neg ? calc_pkg::CODE_MINUS : calc_pkg::CODE_BLANK;
        end else if (in_input) begin
            unique case (pos)
                2'd0:    code = digit0;
                2'd1:    code = digit1;
                default: code = digit2;
            endcase
        end else begin
            code = bcd[bcd_idx*calc_pkg::DIGIT_WIDTH +: calc_pkg::DIGIT_WIDTH];
        end
    end

    assign digit_ctrl = enable ? ~(4'b0001 << pos) : 4'b1111;
    assign digit_seg  = (code <= calc_pkg::CODE_MINUS) ? calc_pkg::SEG_TABLE[code] : 8'hFF;

endmodule

`default_nettype wire

/* verilog/operand_alu.sv */
// operand capture, decimal to binary conversion, operation decode and result register
`timescale 1ns/1ns
`default_nettype none

module operand_alu (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              capture_a,
    input  logic                              capture_b,
    input  logic                              execute,
    input  logic [calc_pkg::DIGIT_WIDTH-1:0]  digit0,
    input  logic [calc_pkg::DIGIT_WIDTH-1:0]  digit1,
    input  logic [calc_pkg::DIGIT_WIDTH-1:0]  digit2,
    input  logic                              negative,
    input  logic [calc_pkg::OP_WIDTH-1:0]     switches,
    output logic                              result_negative,
    output logic [calc_pkg::MAG_WIDTH-1:0]    magnitude,
    output logic                              invalid
);

    logic [calc_pkg::OPERAND_WIDTH-1:0] entry_value, a_mag, b_mag;
    logic                               a_neg, b_neg;
    logic [calc_pkg::OP_WIDTH-1:0]      sw_q;
    logic signed [calc_pkg::MAG_WIDTH:0] a_val, b_val, result, abs_result;

    // hundreds, tens, units
    assign entry_value = digit2 * 7'd100 + digit1 * 4'd10 + digit0;

    always_comb begin
        a_val = (calc_pkg::MAG_WIDTH + 1)'(a_mag);
        b_val = (calc_pkg::MAG_WIDTH + 1)'(b_mag);
        if (a_neg) a_val = -a_val;
        if (b_neg) b_val = -b_val;
        // lowest switch index wins
        if (sw_q[calc_pkg::OP_ADD]) begin
            result = a_val + b_val;
        end else if (sw_q[calc_pkg::OP_SUB]) begin
            result = a_val - b_val;
        end else begin
            result = a_val * b_val;
        end
        abs_result = (result < 0) ? -result : result;
    end

    always_ff @(posedge clk) begin
        if (capture_a) begin
            a_mag <= entry_value;
            a_neg <= negative;
        end
        if (capture_b) begin
            b_mag <= entry_value;
            b_neg <= negative;
            sw_q  <= switches;
        end
        if (execute) magnitude <= abs_result[calc_pkg::MAG_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_negative <= 1'b0;
            invalid         <= 1'b0;
        end else if (execute) begin
            result_negative <= (result < 0);
            invalid         <= ~|sw_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/operand_entry.sv */
// cursor machine with editable digit and sign registers
`timescale 1ns/1ns
`default_nettype none

module operand_entry (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             active,
    input  logic                             clear_entry,
    input  logic                             left,
    input  logic                             right,
    input  logic                             up,
    input  logic                             down,
    output logic [calc_pkg::DIGIT_WIDTH-1:0] digit0,
    output logic [calc_pkg::DIGIT_WIDTH-1:0] digit1,
    output logic [calc_pkg::DIGIT_WIDTH-1:0] digit2,
    output logic                             negative
);

    logic [3:0] cursor;

    // up and down wrap modulo ten
    function automatic logic [calc_pkg::DIGIT_WIDTH-1:0] step(
        input logic [calc_pkg::DIGIT_WIDTH-1:0] d,
        input logic                             inc
    );
        if (inc) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || clear_entry) begin
            cursor   <= calc_pkg::CUR_DIGIT0;
            digit0   <= '0;
            digit1   <= '0;
            digit2   <= '0;
            negative <= 1'b0;
        end else if (active) begin
            if (left && cursor != calc_pkg::CUR_SIGN) begin
                cursor <= cursor << 1;
            end else if (right && cursor != calc_pkg::CUR_DIGIT0) begin
                cursor <= cursor >> 1;
            end
            if (up || down) begin
                unique case (cursor)
                    calc_pkg::CUR_DIGIT0: digit0 <= step(digit0, up);
                    calc_pkg::CUR_DIGIT1: digit1 <= step(digit1, up);
                    calc_pkg::CUR_DIGIT2: digit2 <= step(digit2, up);
                    default:              negative <= ~negative;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/calc_pkg.sv
verilog/button_conditioner.sv
verilog/operand_entry.sv
verilog/calc_control.sv
verilog/operand_alu.sv
verilog/bin_to_bcd.sv
verilog/display_scan.sv
verilog/calc_top.sv
dv/calc_assertions.sv
dv/calc_tb.sv
